// ==== hw/adc_pkg.sv ====
`default_nettype none

package adc_pkg;

    localparam int num_ch = 4;
    localparam int sample_w = 10;
    localparam int ch_sel_w = 2;

    // spi timing, in clk and sclk periods.
    localparam int sclk_div = 4;
    localparam int cs_idle_bits = 2;

    localparam int sclk_div_w = $clog2(sclk_div);
    localparam int conv_bits = sample_w + cs_idle_bits;
    localparam int conv_w = $clog2(conv_bits);

endpackage

`default_nettype wire

// ==== hw/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    localparam int clks_per_bit = 16;
    localparam int clk_cnt_w = $clog2(clks_per_bit);
    // start, eight data bits, stop.
    localparam int uart_bits = 10;
    localparam int uart_bits_w = $clog2(uart_bits);

    // channel number goes in the low two bits.
    localparam logic [7:0] op_read = 8'h10;
    localparam logic [7:0] op_clear = 8'h20;
    localparam logic [7:0] reply_ok = 8'hA5;
    localparam logic [7:0] reply_bad = 8'hEE;

endpackage

`default_nettype wire

// ==== hw/adc_spi_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module adc_spi_rx
    import adc_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset_b,
    input  wire  [num_ch-1:0]           miso,
    output logic                        sclk,
    output logic                        cs_n,
    output logic                        sample_valid,
    output logic [num_ch*sample_w-1:0]  samples
);

    logic [sclk_div_w-1:0] div_cnt;
    logic [conv_w-1:0]     bit_cnt;
    logic [conv_w-1:0]     bit_nxt;
    logic                  period_end;
    logic                  rise;
    logic [sample_w-1:0]   shift_q [num_ch];

    assign period_end = (div_cnt == sclk_div_w'(sclk_div - 1));
    assign rise = (div_cnt == sclk_div_w'(sclk_div / 2 - 1));
    assign bit_nxt = (bit_cnt == conv_w'(conv_bits - 1)) ? '0 : bit_cnt + 1'b1;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            div_cnt <= '0;
            bit_cnt <= conv_w'(conv_bits - 1);
            sclk <= 1'b1;
            cs_n <= 1'b1;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            div_cnt <= period_end ? '0 : div_cnt + 1'b1;
            if (period_end) begin
                bit_cnt <= bit_nxt;
                // each conversion bit opens with a falling sclk.
                cs_n <= (bit_nxt >= conv_w'(sample_w));
                sclk <= (bit_nxt >= conv_w'(sample_w));
            end else if (rise) begin
                sclk <= 1'b1;
                if (!cs_n && bit_cnt == conv_w'(sample_w - 1)) begin
                    sample_valid <= 1'b1;
                end
            end
        end
    end

    // all lanes sampled together, msb first.
    always_ff @(posedge clk) begin
        if (rise && !cs_n) begin
            for (int c = 0; c < num_ch; c++) begin
                shift_q[c] <= {shift_q[c][sample_w-2:0], miso[c]};
            end
        end
    end

    // holds the finished word until the next conversion starts.
    always_comb begin
        for (int c = 0; c < num_ch; c++) begin
            samples[c*sample_w +: sample_w] = shift_q[c];
        end
    end

endmodule

`default_nettype wire

// ==== hw/peak_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module peak_cache
    import adc_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset_b,
    input  wire                         sample_valid,
    input  wire  [num_ch*sample_w-1:0]  samples,
    input  wire                         clear_en,
    input  wire  [ch_sel_w-1:0]         clear_sel,
    input  wire  [ch_sel_w-1:0]         peak_sel,
    output logic [sample_w-1:0]         peak
);

    logic [sample_w-1:0] peak_q [num_ch];

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int c = 0; c < num_ch; c++) begin
                peak_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < num_ch; c++) begin
                // clear beats a same-cycle update.
                if (clear_en && clear_sel == ch_sel_w'(c)) begin
                    peak_q[c] <= '0;
                end else if (sample_valid &&
                             samples[c*sample_w +: sample_w] > peak_q[c]) begin
                    peak_q[c] <= samples[c*sample_w +: sample_w];
                end
            end
        end
    end

    assign peak = peak_q[peak_sel];

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire         clk,
    input  wire         reset_b,
    input  wire         rx,
    output logic [7:0]  rx_data,
    output logic        rx_valid
);

    typedef enum logic [1:0] {st_idle, st_start, st_bits, st_stop} rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_s;
    logic [clk_cnt_w-1:0] cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shift_q;
    logic                 bit_end;

    assign bit_end = (cnt == clk_cnt_w'(clks_per_bit - 1));

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rx_meta <= 1'b1;
            rx_s <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= st_idle;
            cnt <= '0;
            bit_idx <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            cnt <= cnt + 1'b1;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (!rx_s) state <= st_start;
                end
                st_start: begin
                    // half a bit in, so later samples land mid-bit.
                    if (cnt == clk_cnt_w'(clks_per_bit / 2 - 1)) begin
                        cnt <= '0;
                        bit_idx <= '0;
                        state <= rx_s ? st_idle : st_bits;
                    end
                end
                st_bits: begin
                    if (bit_end) begin
                        cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= st_stop;
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        // framing error drops the byte.
                        rx_valid <= rx_s;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // lsb arrives first.
    always_ff @(posedge clk) begin
        if (state == st_bits && bit_end) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

    assign rx_data = shift_q;

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  wire         clk,
    input  wire         reset_b,
    input  wire         tx_req,
    input  wire  [7:0]  tx_data,
    output logic        tx_ack,
    output logic        tx
);

    typedef enum logic [1:0] {st_idle, st_send, st_ack} tx_state_t;

    tx_state_t              state;
    logic [clk_cnt_w-1:0]   cnt;
    logic [uart_bits_w-1:0] bit_cnt;
    logic [8:0]             frame_q;
    logic                   bit_end;

    assign bit_end = (cnt == clk_cnt_w'(clks_per_bit - 1));

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= st_idle;
            cnt <= '0;
            bit_cnt <= '0;
            tx <= 1'b1;
            tx_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // req is low on entry, so a high level is a new request.
                    if (tx_req) begin
                        tx <= 1'b0;
                        cnt <= '0;
                        bit_cnt <= '0;
                        state <= st_send;
                    end
                end
                st_send: begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end) begin
                        if (bit_cnt == uart_bits_w'(uart_bits - 1)) begin
                            tx_ack <= 1'b1;
                            state <= st_ack;
                        end else begin
                            tx <= frame_q[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                st_ack: begin
                    if (!tx_req) begin
                        tx_ack <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // data bits then stop; ones shift in behind.
    always_ff @(posedge clk) begin
        if (state == st_idle && tx_req) begin
            frame_q <= {1'b1, tx_data};
        end else if (state == st_send && bit_end) begin
            frame_q <= {1'b1, frame_q[8:1]};
        end
    end

endmodule

`default_nettype wire

// ==== hw/peak_monitor_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module peak_monitor_ctrl
    import adc_pkg::*;
    import uart_pkg::*;
(
    input  wire                  clk,
    input  wire                  reset_b,
    input  wire  [7:0]           rx_data,
    input  wire                  rx_valid,
    input  wire  [sample_w-1:0]  peak,
    output logic [ch_sel_w-1:0]  peak_sel,
    output logic                 clear_en,
    output logic [ch_sel_w-1:0]  clear_sel,
    output logic                 tx_req,
    output logic [7:0]           tx_data,
    input  wire                  tx_ack
);

    typedef enum logic [1:0] {st_idle, st_req, st_wait_ack, st_wait_low} ctrl_state_t;

    ctrl_state_t state;
    logic [7:0]  reply;
    logic        is_clear;

    assign peak_sel = rx_data[ch_sel_w-1:0];

    always_comb begin
        is_clear = 1'b0;
        if (rx_data[7:2] == op_read[7:2]) begin
            reply = peak[sample_w-1 -: 8];
        end else if (rx_data[7:2] == op_clear[7:2]) begin
            reply = reply_ok;
            is_clear = 1'b1;
        end else begin
            reply = reply_bad;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= st_idle;
            clear_en <= 1'b0;
            tx_req <= 1'b0;
        end else begin
            clear_en <= 1'b0;
            case (state)
                // bytes arriving outside idle are lost.
                st_idle: begin
                    if (rx_valid) begin
                        clear_en <= is_clear;
                        state <= st_req;
                    end
                end
                st_req: begin
                    tx_req <= 1'b1;
                    state <= st_wait_ack;
                end
                st_wait_ack: begin
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                        state <= st_wait_low;
                    end
                end
                st_wait_low: begin
                    if (!tx_ack) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && rx_valid) begin
            tx_data <= reply;
            clear_sel <= rx_data[ch_sel_w-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/adc_peak_monitor_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module adc_peak_monitor_top
    import adc_pkg::*;
(
    input  wire               clk,
    input  wire               reset_b,
    input  wire  [num_ch-1:0] miso,
    output logic              sclk,
    output logic              cs_n,
    input  wire               rx,
    output logic              tx
);

    logic                       sample_valid;
    logic [num_ch*sample_w-1:0] samples;
    logic                       clear_en;
    logic [ch_sel_w-1:0]        clear_sel;
    logic [ch_sel_w-1:0]        peak_sel;
    logic [sample_w-1:0]        peak;
    logic [7:0]                 rx_data;
    logic                       rx_valid;
    logic                       tx_req;
    logic [7:0]                 tx_data;
    logic                       tx_ack;

    adc_spi_rx u_adc_spi_rx (
        .clk          (clk),
        .reset_b      (reset_b),
        .miso         (miso),
        .sclk         (sclk),
        .cs_n         (cs_n),
        .sample_valid (sample_valid),
        .samples      (samples)
    );

    peak_cache u_peak_cache (
        .clk          (clk),
        .reset_b      (reset_b),
        .sample_valid (sample_valid),
        .samples      (samples),
        .clear_en     (clear_en),
        .clear_sel    (clear_sel),
        .peak_sel     (peak_sel),
        .peak         (peak)
    );

    uart_rx u_uart_rx (
        .clk      (clk),
        .reset_b  (reset_b),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_tx u_uart_tx (
        .clk     (clk),
        .reset_b (reset_b),
        .tx_req  (tx_req),
        .tx_data (tx_data),
        .tx_ack  (tx_ack),
        .tx      (tx)
    );

    peak_monitor_ctrl u_ctrl (
        .clk       (clk),
        .reset_b   (reset_b),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .peak      (peak),
        .peak_sel  (peak_sel),
        .clear_en  (clear_en),
        .clear_sel (clear_sel),
        .tx_req    (tx_req),
        .tx_data   (tx_data),
        .tx_ack    (tx_ack)
    );

endmodule

`default_nettype wire

// ==== sim/tb_adc_peak_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_adc_peak_monitor
    import adc_pkg::*;
    import uart_pkg::*;
();

    localparam int frame_clks = conv_bits * sclk_div;
    localparam int byte_clks = uart_bits * clks_per_bit;
    // uart bytes both ways and conversion frames over all tests, doubled.
    localparam int test_bytes = 40;
    localparam int test_frames = 30;
    localparam int timeout_cycles = 2 * (test_bytes * byte_clks + test_frames * frame_clks);

    logic              clk;
    logic              reset_b;
    logic [num_ch-1:0] miso;
    logic              rx;
    wire               sclk;
    wire               cs_n;
    wire               tx;

    logic [sample_w-1:0] lane_value [num_ch];
    logic [sample_w-1:0] lane_shift [num_ch];
    logic [sample_w-1:0] exp_peak [num_ch];
    logic [31:0]         rand_state;
    int                  bit_pos;
    int                  cycle_cnt;

    adc_peak_monitor_top DUT (
        .clk     (clk),
        .reset_b (reset_b),
        .miso    (miso),
        .sclk    (sclk),
        .cs_n    (cs_n),
        .rx      (rx),
        .tx      (tx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // adc lanes. a word is taken at the first falling sclk of a frame.
    initial begin
        miso = '0;
        bit_pos = 0;
        forever begin
            @(negedge sclk);
            #1;
            if (!cs_n) begin
                if (bit_pos == 0) begin
                    lane_shift = lane_value;
                    bit_pos = sample_w;
                end
                bit_pos = bit_pos - 1;
                for (int c = 0; c < num_ch; c++) begin
                    miso[c] = lane_shift[c][bit_pos];
                end
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped by the cycle limit");
    end

    task automatic check(input string name, input logic [7:0] expected,
                         input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic logic [sample_w-1:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[16 +: sample_w];
    endfunction

    // expected peak is the running maximum since the last clear.
    task automatic set_lane(input int c, input logic [sample_w-1:0] v);
        lane_value[c] = v;
        if (v > exp_peak[c]) exp_peak[c] = v;
    endtask

    task automatic wait_frames(input int n);
        repeat (n * frame_clks) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            rx = frame[i];
            repeat (clks_per_bit - 1) @(posedge clk);
        end
    endtask

    task automatic get_byte(output logic [7:0] data);
        @(negedge clk);
        while (tx !== 1'b0) @(negedge clk);
        repeat (clks_per_bit / 2) @(negedge clk);
        check("tx start bit", 8'h00, {7'd0, tx});
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            data[i] = tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        check("tx stop bit", 8'h01, {7'd0, tx});
    endtask

    task automatic command_reply(input logic [7:0] cmd, input logic [7:0] expected,
                                 input string name);
        logic [7:0] reply;
        fork
            send_byte(cmd);
            get_byte(reply);
        join
        check(name, expected, reply);
    endtask

    task automatic read_channel(input int c);
        command_reply(op_read | 8'(c), exp_peak[c][sample_w-1 -: 8],
                      $sformatf("read reply ch%0d", c));
    endtask

    task automatic pick_lane_values();
        logic [sample_w-1:0] v;
        logic                is_new;
        for (int c = 0; c < num_ch; c++) begin
            do begin
                v = next_random();
                is_new = (v[sample_w-1:2] != '0);
                for (int k = 0; k < c; k++) begin
                    if (lane_value[k][sample_w-1:2] == v[sample_w-1:2]) is_new = 1'b0;
                end
            end while (!is_new);
            set_lane(c, v);
        end
    endtask

    task automatic reset_defaults();
        check("tx idle level", 8'h01, {7'd0, tx});
        check("sclk idle level", 8'h01, {7'd0, sclk});
        check("cs_n idle level", 8'h01, {7'd0, cs_n});
        for (int c = 0; c < num_ch; c++) read_channel(c);
    endtask

    // one conversion window and the idle gap after it.
    task automatic spi_frame_shape();
        int   low_clks;
        int   high_clks;
        int   falls;
        logic prev_sclk;
        low_clks = 0;
        high_clks = 0;
        falls = 0;
        prev_sclk = 1'b1;
        @(negedge clk);
        while (cs_n !== 1'b0) @(negedge clk);
        while (cs_n === 1'b0) begin
            low_clks = low_clks + 1;
            if (prev_sclk === 1'b1 && sclk === 1'b0) falls = falls + 1;
            prev_sclk = sclk;
            @(negedge clk);
        end
        while (cs_n !== 1'b0) begin
            high_clks = high_clks + 1;
            @(negedge clk);
        end
        check("cs_n low clocks", 8'(sample_w * sclk_div), 8'(low_clks));
        check("sclk falls per frame", 8'(sample_w), 8'(falls));
        check("cs_n high clocks", 8'(cs_idle_bits * sclk_div), 8'(high_clks));
    endtask

    task automatic separate_lanes();
        pick_lane_values();
        wait_frames(3);
        for (int c = 0; c < num_ch; c++) read_channel(c);
    endtask

    task automatic hold_peak();
        set_lane(0, 10'h3FC);
        wait_frames(3);
        read_channel(0);
        set_lane(0, 10'h004);
        wait_frames(3);
        read_channel(0);
    endtask

    task automatic clear_one_channel();
        set_lane(2, exp_peak[2] >> 1);
        wait_frames(3);
        command_reply(op_clear | 8'd2, reply_ok, "clear reply ch2");
        // the lane keeps feeding its current value after the clear.
        exp_peak[2] = lane_value[2];
        wait_frames(3);
        for (int c = 0; c < num_ch; c++) read_channel(c);
    endtask

    task automatic reject_bad_opcode();
        command_reply(8'h55, reply_bad, "unknown opcode reply");
        read_channel(1);
    endtask

    task automatic drop_while_busy();
        logic [7:0] reply;
        fork
            begin
                send_byte(op_read | 8'd3);
                // lands while the first reply is still on tx.
                send_byte(op_read | 8'd0);
            end
            get_byte(reply);
        join
        check("reply while busy", exp_peak[3][sample_w-1 -: 8], reply);
        repeat (2 * byte_clks) begin
            @(negedge clk);
            check("tx after dropped command", 8'h01, {7'd0, tx});
        end
    endtask

    initial begin
        reset_b = 1'b0;
        rx = 1'b1;
        rand_state = 32'd63;
        for (int c = 0; c < num_ch; c++) begin
            lane_value[c] = '0;
            exp_peak[c] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset_b = 1'b1;
        reset_defaults();
        spi_frame_shape();
        separate_lanes();
        hold_peak();
        clear_one_channel();
        reject_bad_opcode();
        drop_while_busy();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hw/adc_pkg.sv
hw/uart_pkg.sv
hw/adc_spi_rx.sv
hw/peak_cache.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/peak_monitor_ctrl.sv
hw/adc_peak_monitor_top.sv
sim/tb_adc_peak_monitor.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_adc_peak_monitor
FILELIST  = all.f
BUILD_DIR = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
